/* include/mic_defs.svh */
/*
 * Microphone array geometry
 * Channel count, bit clock divider, word and sample widths, frame length
 */

`ifndef MIC_DEFS_SVH
`define MIC_DEFS_SVH

// Number of SPI microphones sharing one chip select and one bit clock
`define MIC_CHANNELS 4

// Clock cycles per half period of the bit clock
// The bit clock runs at clk / (2 * MIC_SCK_HALF)
`define MIC_SCK_HALF 2

// Bits shifted out of each microphone per frame
`define MIC_WORD_BITS 16

// Width of the useful sample at the bottom of each word
`define MIC_SAMPLE_BITS 12

// Bit clock periods in one frame, first half with chip select low
`define MIC_FRAME_SCKS 32

`endif

/* rtl/mic_array_pkg.sv */
/*
 * Array result types
 * Types for the sum, loudest channel index and framing error mask
 */

`include "mic_defs.svh"

package mic_array_pkg;

    // Channel index width
    localparam int MIC_CHAN_BITS = $clog2(`MIC_CHANNELS);

    // The sum needs room for every channel at full scale
    localparam int MIC_SUM_BITS = `MIC_SAMPLE_BITS + MIC_CHAN_BITS;

    // Sum of all channel samples, never overflows
    typedef logic [MIC_SUM_BITS-1:0] mic_sum_t;

    // Index of one channel
    typedef logic [MIC_CHAN_BITS-1:0] mic_chan_t;

    // One bit per channel
    // A set bit marks a word whose lead field was not zero
    typedef logic [`MIC_CHANNELS-1:0] mic_mask_t;

endpackage

/* rtl/mic_array_top.sv */
/*
 * Four channel microphone array front end
 * Shared timing, one capture per mic and a frame collector
 */

`timescale 1ns/10ps

`include "mic_defs.svh"

module mic_array_top (
    input  logic                                      clk,
    input  logic                                      rst,
    input  logic [`MIC_CHANNELS-1:0]                  sdo,
    output logic                                      sck,
    output logic                                      cs,
    output logic [`MIC_CHANNELS*`MIC_SAMPLE_BITS-1:0] samples,
    output mic_array_pkg::mic_sum_t                   sum,
    output mic_array_pkg::mic_chan_t                  peak,
    output mic_array_pkg::mic_mask_t                  err_mask,
    output logic                                      frame_valid
);

    import mic_frame_pkg::*;

    // Per channel capture results
    mic_sample_t              value [`MIC_CHANNELS];
    logic [`MIC_CHANNELS-1:0] lead_err;
    logic [`MIC_CHANNELS-1:0] ready;

    // Collected samples before they are packed onto the output bus
    mic_sample_t              samples_arr [`MIC_CHANNELS];

    mic_bus_if bus ();

    //----------------------------------------------------------------------
    // Timing and capture
    //----------------------------------------------------------------------

    mic_sck_gen u_gen (
        .clk (clk),
        .rst (rst),
        .bus (bus.gen)
    );

    // The mics share clock and select, only the data line is per channel
    assign sck = bus.sck;
    assign cs  = bus.cs;

    for (genvar ch = 0; ch < `MIC_CHANNELS; ch++)
    begin : g_cap
        mic_spi_capture u_cap (
            .clk      (clk),
            .rst      (rst),
            .bus      (bus.cap),
            .sdo      (sdo[ch]),
            .value    (value[ch]),
            .lead_err (lead_err[ch]),
            .ready    (ready[ch])
        );

        // Channel 0 sits in the lowest bits of the flat sample bus
        assign samples[ch*`MIC_SAMPLE_BITS +: `MIC_SAMPLE_BITS] = samples_arr[ch];
    end

    //----------------------------------------------------------------------
    // Collection
    //----------------------------------------------------------------------

    mic_frame_collector u_coll (
        .clk         (clk),
        .rst         (rst),
        .bus         (bus.mon),
        .value       (value),
        .lead_err    (lead_err),
        .ready       (ready),
        .samples     (samples_arr),
        .sum         (sum),
        .peak        (peak),
        .err_mask    (err_mask),
        .frame_valid (frame_valid)
    );

endmodule

/* rtl/mic_bus_if.sv */
/*
 * Shared microphone timing bundle
 * Bit clock, chip select and the two frame strobes
 */

`timescale 1ns/10ps

interface mic_bus_if;

    // Bit clock and chip select, both go out to every mic
    logic sck;
    logic cs;

    // One clk pulse per data bit while chip select is low
    logic sample_stb;

    // One clk pulse at the first bit clock rise with chip select high
    logic frame_end;

    // The timing generator owns all four signals
    modport gen (
        output sck,
        output cs,
        output sample_stb,
        output frame_end
    );

    // Captures only need the strobes
    modport cap (
        input sample_stb,
        input frame_end
    );

    // The collector only watches for the end of the frame
    modport mon (
        input frame_end
    );

endinterface

/* rtl/mic_frame_collector.sv */
/*
 * Frame collector
 * Waits for every channel, then latches samples, sum, peak and error mask
 */

`timescale 1ns/10ps

`include "mic_defs.svh"

module mic_frame_collector (
    input  logic                        clk,
    input  logic                        rst,
    mic_bus_if.mon                      bus,
    input  mic_frame_pkg::mic_sample_t  value [`MIC_CHANNELS],
    input  logic [`MIC_CHANNELS-1:0]    lead_err,
    input  logic [`MIC_CHANNELS-1:0]    ready,
    output mic_frame_pkg::mic_sample_t  samples [`MIC_CHANNELS],
    output mic_array_pkg::mic_sum_t     sum,
    output mic_array_pkg::mic_chan_t    peak,
    output mic_array_pkg::mic_mask_t    err_mask,
    output logic                        frame_valid
);

    import mic_frame_pkg::*;
    import mic_array_pkg::*;

    mic_mask_t   seen;
    mic_mask_t   seen_next;
    logic        all_in;
    mic_sum_t    sum_c;
    mic_chan_t   peak_c;
    mic_sample_t best_c;

    //----------------------------------------------------------------------
    // Ready tracking
    //----------------------------------------------------------------------

    assign seen_next = seen | ready;

    // Fires once, on the cycle the last missing channel shows up
    assign all_in = (&seen_next) && !(&seen);

    // The frame end strobe opens a new round of ready collection
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            seen <= '0;
        else if (bus.frame_end)
            seen <= '0;
        else
            seen <= seen_next;
    end

    //----------------------------------------------------------------------
    // Sum and loudest channel
    //----------------------------------------------------------------------

    // Strict compare keeps the lowest index on a tie
    always_comb
    begin
        sum_c  = '0;
        best_c = value[0];
        peak_c = '0;
        for (int ch = 0; ch < `MIC_CHANNELS; ch++)
        begin
            sum_c = sum_c + mic_sum_t'(value[ch]);
            if (value[ch] > best_c)
            begin
                best_c = value[ch];
                peak_c = mic_chan_t'(ch);
            end
        end
    end

    //----------------------------------------------------------------------
    // Result registers
    //----------------------------------------------------------------------

    // Results hold until the next complete frame replaces them
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            samples     <= '{default: '0};
            sum         <= '0;
            peak        <= '0;
            err_mask    <= '0;
            frame_valid <= 1'b0;
        end
        else
        begin
            frame_valid <= all_in;
            if (all_in)
            begin
                samples  <= value;
                sum      <= sum_c;
                peak     <= peak_c;
                err_mask <= lead_err;
            end
        end
    end

    // Each capture reports once per frame, a repeat means lost alignment
    a_no_repeat: assert property (@(posedge clk) disable iff (rst)
        (ready & seen) == '0)
        else $error("channel ready repeated within a frame, mask %b", ready & seen);

endmodule

/* rtl/mic_frame_pkg.sv */
/*
 * Microphone word types
 * One SPI word from a single mic, seen as raw bits or as lead and sample
 */

`include "mic_defs.svh"

package mic_frame_pkg;

    // Leading bits ahead of the sample, the ADC sends zeros here
    localparam int MIC_LEAD_BITS = `MIC_WORD_BITS - `MIC_SAMPLE_BITS;

    // Unsigned sample, zero up to full scale
    typedef logic [`MIC_SAMPLE_BITS-1:0] mic_sample_t;

    typedef logic [MIC_LEAD_BITS-1:0] mic_lead_t;

    // The word as it arrives, MSB first
    typedef struct packed {
        mic_lead_t   lead;
        mic_sample_t sample;
    } mic_word_fields_t;

    // Same 16 bits decoded two ways
    // The shift register fills raw, the frame end reads fields
    typedef union packed {
        logic [`MIC_WORD_BITS-1:0] raw;
        mic_word_fields_t          fields;
    } mic_word_u;

endpackage

/* rtl/mic_sck_gen.sv */
/*
 * Microphone timing generator
 * Divides clk into the bit clock, and makes chip select and frame strobes
 */

`timescale 1ns/10ps

`include "mic_defs.svh"

module mic_sck_gen (
    input logic clk,
    input logic rst,
    mic_bus_if.gen bus
);

    // Divider counter wide enough to hold MIC_SCK_HALF - 1
    localparam int DIV_W = $clog2(`MIC_SCK_HALF + 1);

    // Bit counter wraps once per frame
    localparam int CNT_W = $clog2(`MIC_FRAME_SCKS);

    // Count value where chip select goes high and the frame ends
    localparam int HALF_FRAME = `MIC_FRAME_SCKS / 2;

    logic [DIV_W-1:0] div_cnt;
    logic [CNT_W-1:0] bit_cnt;
    logic [CNT_W-1:0] bit_cnt_next;
    logic             div_done;

    //----------------------------------------------------------------------
    // Divider and bit counter
    //----------------------------------------------------------------------

    assign div_done     = (div_cnt == DIV_W'(`MIC_SCK_HALF - 1));
    assign bit_cnt_next = bit_cnt + 1'b1;

    // Chip select is the top bit, so it is low for the first half frame
    assign bus.cs = bit_cnt[CNT_W-1];

    // The bit counter starts at its last value to hold chip select high
    // The first bit clock rise then opens a fresh frame
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            div_cnt        <= '0;
            bit_cnt        <= '1;
            bus.sck        <= 1'b0;
            bus.sample_stb <= 1'b0;
            bus.frame_end  <= 1'b0;
        end
        else
        begin
            bus.sample_stb <= 1'b0;
            bus.frame_end  <= 1'b0;

            if (div_done)
            begin
                div_cnt <= '0;
                bus.sck <= ~bus.sck;

                // Everything advances on the low to high toggle only
                if (!bus.sck)
                begin
                    bit_cnt <= bit_cnt_next;

                    // Sample while the new count keeps chip select low
                    bus.sample_stb <= !bit_cnt_next[CNT_W-1];

                    // First rise with chip select high closes the word
                    bus.frame_end <= (bit_cnt_next == CNT_W'(HALF_FRAME));
                end
            end
            else
            begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    //----------------------------------------------------------------------
    // Checks
    //----------------------------------------------------------------------

    // Data bits are only taken inside the chip select window
    a_stb_in_window: assert property (@(posedge clk) disable iff (rst)
        bus.sample_stb |-> !bus.cs)
        else $error("sample_stb fired with cs high");

    // The captures treat these two strobes as exclusive events
    a_stb_excl: assert property (@(posedge clk) disable iff (rst)
        !(bus.sample_stb && bus.frame_end))
        else $error("sample_stb and frame_end in the same cycle");

endmodule

/* rtl/mic_spi_capture.sv */
/*
 * Single channel SPI capture
 * Shifts in one word per frame, then reports the sample and a lead error
 */

`timescale 1ns/10ps

`include "mic_defs.svh"

module mic_spi_capture (
    input  logic                      clk,
    input  logic                      rst,
    mic_bus_if.cap                    bus,
    input  logic                      sdo,
    output mic_frame_pkg::mic_sample_t value,
    output logic                      lead_err,
    output logic                      ready
);

    import mic_frame_pkg::*;

    // Room to count one more shift than a word holds
    localparam int SHIFT_W = $clog2(`MIC_WORD_BITS + 1);

    mic_word_u          word;
    logic [SHIFT_W-1:0] shift_cnt;

    //----------------------------------------------------------------------
    // Shift register
    //----------------------------------------------------------------------

    // First bit in is the MSB and it ends up at the top of raw
    // The word is overwritten in full every frame
    always_ff @(posedge clk)
    begin
        if (bus.sample_stb)
            word.raw <= {word.raw[`MIC_WORD_BITS-2:0], sdo};
    end

    // Shifts since the last frame end
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            shift_cnt <= '0;
        else if (bus.frame_end)
            shift_cnt <= '0;
        else if (bus.sample_stb)
            shift_cnt <= shift_cnt + 1'b1;
    end

    //----------------------------------------------------------------------
    // Word output
    //----------------------------------------------------------------------

    // At the end of the frame the word is read through its fields view
    // ready lines up with the new value in the following cycle
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            value    <= '0;
            lead_err <= 1'b0;
            ready    <= 1'b0;
        end
        else
        begin
            ready <= bus.frame_end;
            if (bus.frame_end)
            begin
                value    <= word.fields.sample;
                lead_err <= |word.fields.lead;
            end
        end
    end

    // A word is complete only if the window gave exactly one bit per slot
    a_word_len: assert property (@(posedge clk) disable iff (rst)
        bus.frame_end |-> (shift_cnt == SHIFT_W'(`MIC_WORD_BITS)))
        else $error("capture saw %0d shifts in a frame", shift_cnt);

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the microphone array simulation with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    --top-module tb_mic_array \
    -f sources.f \
    --Mdir obj_dir \
    -o sim_mic_array

./obj_dir/sim_mic_array > sim.log 2>&1 || true
cat sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

/* sources.f */
+incdir+include
rtl/mic_frame_pkg.sv
rtl/mic_array_pkg.sv
rtl/mic_bus_if.sv
rtl/mic_sck_gen.sv
rtl/mic_spi_capture.sv
rtl/mic_frame_collector.sv
rtl/mic_array_top.sv
testbench/tb_mic_array.sv

/* testbench/tb_mic_array.sv */
/*
 * Testbench for the four channel microphone array front end
 * Seeded random mic words, a reference model and one compare task per result
 */

`timescale 1ns/10ps

`include "mic_defs.svh"

module tb_mic_array;

    import mic_frame_pkg::*;
    import mic_array_pkg::*;

    localparam int NUM_FRAMES     = 40;
    localparam int TIMEOUT_CYCLES = 400;
    localparam int HALF_FRAME     = `MIC_FRAME_SCKS / 2;

    // Expected results of one frame as the model works them out
    typedef struct packed {
        mic_sample_t [`MIC_CHANNELS-1:0] smp;
        mic_sum_t                        sum;
        mic_chan_t                       peak;
        mic_mask_t                       mask;
    } frame_exp_t;

    logic                                      clk;
    logic                                      rst;
    logic [`MIC_CHANNELS-1:0]                  sdo;
    logic                                      sck;
    logic                                      cs;
    logic [`MIC_CHANNELS*`MIC_SAMPLE_BITS-1:0] samples;
    mic_sum_t                                  sum;
    mic_chan_t                                 peak;
    mic_mask_t                                 err_mask;
    logic                                      frame_valid;

    integer     seed;
    int         sample_errs;
    int         sum_errs;
    int         peak_errs;
    int         mask_errs;
    int         timing_errs;
    int         window_errs;
    frame_exp_t exp_q [$];
    mic_word_u  words [`MIC_CHANNELS];

    // State of the chip select window monitor
    logic prev_sck;
    logic prev_cs;
    int   low_rises;
    int   high_rises;
    logic window_seen;

    mic_array_top uut (
        .clk         (clk),
        .rst         (rst),
        .sdo         (sdo),
        .sck         (sck),
        .cs          (cs),
        .samples     (samples),
        .sum         (sum),
        .peak        (peak),
        .err_mask    (err_mask),
        .frame_valid (frame_valid)
    );

    always #50 clk = ~clk;

    //----------------------------------------------------------------------
    // Compare tasks
    //----------------------------------------------------------------------

    task automatic check_sample(input int ch, input mic_sample_t got, input mic_sample_t exp);
        if (got !== exp)
        begin
            $display("ERROR samples[%0d]: got %h expected %h", ch, got, exp);
            sample_errs++;
        end
    endtask

    task automatic check_sum(input mic_sum_t got, input mic_sum_t exp);
        if (got !== exp)
        begin
            $display("ERROR sum: got %h expected %h", got, exp);
            sum_errs++;
        end
    endtask

    task automatic check_peak(input mic_chan_t got, input mic_chan_t exp);
        if (got !== exp)
        begin
            $display("ERROR peak: got %h expected %h", got, exp);
            peak_errs++;
        end
    endtask

    task automatic check_mask(input mic_mask_t got, input mic_mask_t exp);
        if (got !== exp)
        begin
            $display("ERROR err_mask: got %h expected %h", got, exp);
            mask_errs++;
        end
    endtask

    //----------------------------------------------------------------------
    // Waits bounded by their own cycle counts
    //----------------------------------------------------------------------

    // Between frame_valid pulses no other pulse may show up
    task automatic wait_cs_fall(output bit ok);
        logic last_cs;
        int   n;
        last_cs = cs;
        ok = 1'b0;
        for (n = 0; n < TIMEOUT_CYCLES && !ok; n++)
        begin
            @(posedge clk);
            #1;
            if (frame_valid)
            begin
                $display("frame_valid pulsed while no frame was complete");
                timing_errs++;
            end
            ok = last_cs && !cs;
            last_cs = cs;
        end
        if (!ok)
        begin
            $display("Timed out waiting for cs to fall");
            timing_errs++;
        end
    endtask

    task automatic wait_sck_fall(output bit ok);
        logic last_sck;
        int   n;
        last_sck = sck;
        ok = 1'b0;
        for (n = 0; n < TIMEOUT_CYCLES && !ok; n++)
        begin
            @(posedge clk);
            #1;
            if (frame_valid)
            begin
                $display("frame_valid pulsed in the middle of a frame");
                timing_errs++;
            end
            ok = last_sck && !sck;
            last_sck = sck;
        end
        if (!ok)
        begin
            $display("Timed out waiting for sck to fall");
            timing_errs++;
        end
    endtask

    task automatic wait_frame_valid(output bit ok);
        int n;
        ok = 1'b0;
        for (n = 0; n < TIMEOUT_CYCLES && !ok; n++)
        begin
            @(posedge clk);
            #1;
            ok = frame_valid;
        end
        if (!ok)
        begin
            $display("Timed out waiting for frame_valid");
            timing_errs++;
        end
    endtask

    //----------------------------------------------------------------------
    // Microphone models and reference model
    //----------------------------------------------------------------------

    // Draws new words for all mics and queues the expected results
    task automatic draw_words(input int frame);
        frame_exp_t  e;
        mic_sample_t best;
        int          ch;
        e = '0;
        for (ch = 0; ch < `MIC_CHANNELS; ch++)
        begin
            words[ch].raw = 16'($random(seed));
            // Roughly one word in eight carries a bad lead field
            if (($random(seed) & 7) == 0)
            begin
                if (words[ch].fields.lead == '0)
                    words[ch].fields.lead = mic_lead_t'(1);
            end
            else
                words[ch].fields.lead = '0;
        end
        // Some frames carry equal samples so the lowest index has to win
        if (frame % 10 == 4)
        begin
            for (ch = 1; ch < `MIC_CHANNELS; ch++)
                words[ch].fields.sample = words[0].fields.sample;
        end
        else if (frame % 10 == 7)
        begin
            words[1].fields.sample = '1;
            words[3].fields.sample = '1;
        end
        best = '0;
        for (ch = 0; ch < `MIC_CHANNELS; ch++)
        begin
            e.smp[ch]  = words[ch].fields.sample;
            e.sum      = e.sum + mic_sum_t'(words[ch].fields.sample);
            e.mask[ch] = (words[ch].fields.lead != '0);
            if (words[ch].fields.sample > best)
                best = words[ch].fields.sample;
        end
        // Walking down from the top channel leaves the lowest index that hits the maximum
        for (ch = `MIC_CHANNELS - 1; ch >= 0; ch--)
        begin
            if (words[ch].fields.sample == best)
                e.peak = mic_chan_t'(ch);
        end
        exp_q.push_back(e);
    endtask

    task automatic drive_bit(input int b);
        int ch;
        for (ch = 0; ch < `MIC_CHANNELS; ch++)
            sdo[ch] = words[ch].raw[b];
    endtask

    // The MSB goes out at the cs fall and each later bit at a falling sck
    task automatic shift_out(output bit ok);
        int b;
        drive_bit(`MIC_WORD_BITS - 1);
        ok = 1'b1;
        for (b = `MIC_WORD_BITS - 2; b >= 0 && ok; b--)
        begin
            wait_sck_fall(ok);
            if (ok)
                drive_bit(b);
        end
    endtask

    task automatic check_frame(input bit skip);
        frame_exp_t e;
        int         ch;
        e = exp_q.pop_front();
        if (!skip)
        begin
            for (ch = 0; ch < `MIC_CHANNELS; ch++)
                check_sample(ch, samples[ch*`MIC_SAMPLE_BITS +: `MIC_SAMPLE_BITS], e.smp[ch]);
            check_sum(sum, e.sum);
            check_peak(peak, e.peak);
            check_mask(err_mask, e.mask);
        end
    endtask

    //----------------------------------------------------------------------
    // Chip select window monitor
    //----------------------------------------------------------------------

    // Counts sck rises in each half of the frame
    always @(posedge clk)
    begin
        #1;
        if (rst)
        begin
            prev_sck    = 1'b0;
            prev_cs     = 1'b1;
            low_rises   = 0;
            high_rises  = 0;
            window_seen = 1'b0;
        end
        else
        begin
            if (prev_cs && !cs)
            begin
                if (window_seen && high_rises != HALF_FRAME)
                begin
                    $display("cs stayed high for %0d sck rises instead of %0d",
                             high_rises, HALF_FRAME);
                    window_errs++;
                end
                low_rises = 0;
            end
            else if (!prev_cs && cs)
            begin
                if (low_rises != HALF_FRAME)
                begin
                    $display("cs was low for %0d sck rises instead of %0d",
                             low_rises, HALF_FRAME);
                    window_errs++;
                end
                high_rises  = 0;
                window_seen = 1'b1;
            end
            if (!prev_sck && sck)
            begin
                if (cs)
                    high_rises++;
                else
                    low_rises++;
            end
            prev_sck = sck;
            prev_cs  = cs;
        end
    end

    //----------------------------------------------------------------------
    // Main sequence
    //----------------------------------------------------------------------

    initial
    begin
        bit ok;
        int frame;
        int total;
        clk         = 1'b0;
        rst         = 1'b1;
        sdo         = '0;
        seed        = 39;
        sample_errs = 0;
        sum_errs    = 0;
        peak_errs   = 0;
        mask_errs   = 0;
        timing_errs = 0;
        window_errs = 0;

        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        if (cs !== 1'b1 || sck !== 1'b0 || frame_valid !== 1'b0)
        begin
            $display("Idle state after reset is wrong: cs %b sck %b frame_valid %b",
                     cs, sck, frame_valid);
            timing_errs++;
        end

        // The first frame only lines the models up with cs
        ok = 1'b1;
        for (frame = 0; frame < NUM_FRAMES && ok; frame++)
        begin
            wait_cs_fall(ok);
            if (ok)
            begin
                draw_words(frame);
                shift_out(ok);
            end
            if (ok)
                wait_frame_valid(ok);
            if (ok)
                check_frame(frame == 0);
        end

        total = sample_errs + sum_errs + peak_errs + mask_errs + timing_errs + window_errs;
        $display("Errors: sample %0d sum %0d peak %0d mask %0d timing %0d window %0d",
                 sample_errs, sum_errs, peak_errs, mask_errs, timing_errs, window_errs);
        if (ok && total == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule
